/* design/trellis_config.svh */
`ifndef TRELLIS_CONFIG_SVH
`define TRELLIS_CONFIG_SVH

// width of branch and accumulated metrics, two's complement
`define METRIC_WIDTH 12

// trellis states, a power of four for the 4-way tree
`define NUM_STATES 64

// comparator tree levels, log4 of NUM_STATES
`define COMP_STAGES 3

`endif

/* design/trellisPkg.sv */
`include "trellis_config.svh"

package trellisPkg;

   // one signed metric word, branch or accumulated
   typedef logic signed [`METRIC_WIDTH-1:0] metric_t;

   // state index 0..NUM_STATES-1
   typedef logic [$clog2(`NUM_STATES)-1:0] stateIndex_t;

   // winner record carried through the max tree
   typedef struct packed {
      stateIndex_t index;   // state that holds the max
      metric_t     value;   // its accumulated metric
   } maxResult_t;

   // one metric per state, element i belongs to state i
   typedef metric_t [`NUM_STATES-1:0] metricBank_t;

   // branch metric loader FSM
   typedef enum logic {
      collecting,   // waiting for the rest of the 64 words
      full          // bank complete, waiting for symEn
   } loaderState_e;

endpackage

/* design/branchMetricLoader.sv */
`timescale 1ns/1ps
`include "trellis_config.svh"

// Serial branch metrics are written slot by slot into a bank. Once all
// NUM_STATES words are in, the next symEn commits the bank with a
// one-cycle update pulse. A symEn that comes too early is flagged on
// missedSym and the partial bank stays as it is.
module branchMetricLoader (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    bmEn,
   input  trellisPkg::metric_t     bmData,
   input  logic                    symEn,
   output trellisPkg::metricBank_t bmBank,
   output logic                    update,
   output logic                    missedSym
);

   localparam trellisPkg::stateIndex_t lastSlot =
      trellisPkg::stateIndex_t'(`NUM_STATES - 1);

   trellisPkg::loaderState_e state;
   trellisPkg::stateIndex_t  count;   // next slot to be written

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= trellisPkg::collecting;
         count     <= '0;
         update    <= 1'b0;
         missedSym <= 1'b0;
      end else begin
         update    <= 1'b0;   // both outputs are single pulses
         missedSym <= 1'b0;
         case (state)
            trellisPkg::collecting: begin
               if (symEn) begin
                  missedSym <= 1'b1;   // bank not complete yet
               end
               if (bmEn) begin
                  if (count == lastSlot) begin
                     state <= trellisPkg::full;
                     count <= '0;
                  end else begin
                     count <= count + 1'b1;
                  end
               end
            end
            trellisPkg::full: begin
               // extra words are dropped here, no back-pressure
               if (symEn) begin
                  update <= 1'b1;
                  state  <= trellisPkg::collecting;
                  count  <= '0;
               end
            end
            default: begin
               state <= trellisPkg::collecting;
               count <= '0;
            end
         endcase
      end
   end

   // bank write
   // accumulators sample bmBank one edge after update, so a word written
   // on that same edge is still the old one for them
   always_ff @(posedge clk) begin
      if (bmEn && (state == trellisPkg::collecting)) begin
         bmBank[count] <= bmData;
      end
   end

endmodule

/* design/metricAccumulator.sv */
`timescale 1ns/1ps
`include "trellis_config.svh"

// Accumulated path metric of one trellis state. Each update adds the new
// branch metric and removes the previous symbol's maximum, then clamps
// to the metric range.
module metricAccumulator (
   input  logic                clk,
   input  logic                reset,
   input  logic                update,
   input  trellisPkg::metric_t branchMet,
   input  trellisPkg::metric_t normVal,
   output trellisPkg::metric_t accMet
);

   localparam int width = `METRIC_WIDTH;

   // two guard bits cover a + b - c without wrap
   localparam logic signed [width+1:0] maxPos = (2 ** (width - 1)) - 1;
   localparam logic signed [width+1:0] minNeg = -(2 ** (width - 1));

   logic signed [width+1:0] sum;
   trellisPkg::metric_t     satSum;

   always_comb begin
      sum = accMet + branchMet - normVal;   // signed, extended
      if (sum > maxPos) begin
         satSum = maxPos[width-1:0];
      end else if (sum < minNeg) begin
         satSum = minNeg[width-1:0];
      end else begin
         satSum = sum[width-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         accMet <= '0;
      end else if (update) begin
         accMet <= satSum;
      end
   end

endmodule

/* design/comp4Max.sv */
`timescale 1ns/1ps

// Registered four-way signed maximum. The winner keeps the index it came
// in with, shifted by indexOffset. Equal values go to the higher input
// position, which is also the higher state index.
module comp4Max #(
   parameter int indexOffset = 0   // first state of this group in stage 1
) (
   input  logic                    clk,
   input  trellisPkg::metric_t     in0,
   input  trellisPkg::metric_t     in1,
   input  trellisPkg::metric_t     in2,
   input  trellisPkg::metric_t     in3,
   input  trellisPkg::stateIndex_t indexIn0,
   input  trellisPkg::stateIndex_t indexIn1,
   input  trellisPkg::stateIndex_t indexIn2,
   input  trellisPkg::stateIndex_t indexIn3,
   output trellisPkg::maxResult_t  win
);

   localparam trellisPkg::stateIndex_t offset = trellisPkg::stateIndex_t'(indexOffset);

   trellisPkg::metric_t     lowVal;    // winner of in0/in1
   trellisPkg::metric_t     highVal;   // winner of in2/in3
   trellisPkg::stateIndex_t lowIdx;
   trellisPkg::stateIndex_t highIdx;
   trellisPkg::maxResult_t  nextWin;

   always_comb begin
      // >= lets the upper input take a tie
      if (in1 >= in0) begin
         lowVal = in1;
         lowIdx = indexIn1;
      end else begin
         lowVal = in0;
         lowIdx = indexIn0;
      end
      if (in3 >= in2) begin
         highVal = in3;
         highIdx = indexIn3;
      end else begin
         highVal = in2;
         highIdx = indexIn2;
      end
      if (highVal >= lowVal) begin
         nextWin.value = highVal;
         nextWin.index = highIdx + offset;
      end else begin
         nextWin.value = lowVal;
         nextWin.index = lowIdx + offset;
      end
   end

   always_ff @(posedge clk) begin
      win <= nextWin;
   end

endmodule

/* design/maxMetricFinder.sv */
`timescale 1ns/1ps
`include "trellis_config.svh"

// Three-level tree of comp4Max over all accumulated metrics.
// update -> accumulators (1) -> stage 1 (2) -> stage 2 (3) -> stage 3 (4)
// -> result latch and maxValid (5)
// The latched maximum value also serves as normVal for the next symbol.
module maxMetricFinder (
   input  logic                    clk,
   input  logic                    reset,
   input  logic                    update,
   input  trellisPkg::metricBank_t accBank,
   output trellisPkg::maxResult_t  result,
   output logic                    maxValid,
   output trellisPkg::metric_t     normVal
);

   localparam int stage1Count = `NUM_STATES / 4;
   localparam int stage2Count = stage1Count / 4;

   trellisPkg::maxResult_t s1Win [stage1Count];
   trellisPkg::maxResult_t s2Win [stage2Count];
   trellisPkg::maxResult_t s3Win;

   // bit 0 lines up with the accumulator register, bit k with tree stage k
   logic [`COMP_STAGES:0] validPipe;

   // stage 1, local index 0..3 plus the group's first state
   for (genvar g = 0; g < stage1Count; g++) begin : genStage1
      comp4Max #(
         .indexOffset(4 * g)
      ) compS1 (
         .clk      (clk),
         .in0      (accBank[4*g]),
         .in1      (accBank[4*g+1]),
         .in2      (accBank[4*g+2]),
         .in3      (accBank[4*g+3]),
         .indexIn0 (trellisPkg::stateIndex_t'(0)),
         .indexIn1 (trellisPkg::stateIndex_t'(1)),
         .indexIn2 (trellisPkg::stateIndex_t'(2)),
         .indexIn3 (trellisPkg::stateIndex_t'(3)),
         .win      (s1Win[g])
      );
   end

   // stage 2, indices already absolute
   for (genvar g = 0; g < stage2Count; g++) begin : genStage2
      comp4Max #(
         .indexOffset(0)
      ) compS2 (
         .clk      (clk),
         .in0      (s1Win[4*g].value),
         .in1      (s1Win[4*g+1].value),
         .in2      (s1Win[4*g+2].value),
         .in3      (s1Win[4*g+3].value),
         .indexIn0 (s1Win[4*g].index),
         .indexIn1 (s1Win[4*g+1].index),
         .indexIn2 (s1Win[4*g+2].index),
         .indexIn3 (s1Win[4*g+3].index),
         .win      (s2Win[g])
      );
   end

   // final compare
   comp4Max #(
      .indexOffset(0)
   ) compS3 (
      .clk      (clk),
      .in0      (s2Win[0].value),
      .in1      (s2Win[1].value),
      .in2      (s2Win[2].value),
      .in3      (s2Win[3].value),
      .indexIn0 (s2Win[0].index),
      .indexIn1 (s2Win[1].index),
      .indexIn2 (s2Win[2].index),
      .indexIn3 (s2Win[3].index),
      .win      (s3Win)
   );

   always_ff @(posedge clk) begin
      if (reset) begin
         validPipe <= '0;
         maxValid  <= 1'b0;
         result    <= '0;
      end else begin
         validPipe <= {validPipe[`COMP_STAGES-1:0], update};
         maxValid  <= validPipe[`COMP_STAGES];
         if (validPipe[`COMP_STAGES]) begin
            result <= s3Win;   // hold until the next symbol
         end
      end
   end

   assign normVal = result.value;   // previous symbol's max

endmodule

/* design/trellisMetricUnit.sv */
`timescale 1ns/1ps
`include "trellis_config.svh"

// Metric back end of the trellis detector: serial branch metric
// loader, one accumulator per state and the max-metric tree.
module trellisMetricUnit (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   bmEn,
   input  trellisPkg::metric_t    bmData,
   input  logic                   symEn,
   output trellisPkg::maxResult_t result,
   output logic                   maxValid,
   output logic                   missedSym
);

   wire trellisPkg::metricBank_t bmBank;    // committed branch metrics
   wire trellisPkg::metricBank_t accBank;   // accumulated metrics
   wire trellisPkg::metric_t     normVal;
   wire logic                    update;

   branchMetricLoader loader (
      .clk       (clk),
      .reset     (reset),
      .bmEn      (bmEn),
      .bmData    (bmData),
      .symEn     (symEn),
      .bmBank    (bmBank),
      .update    (update),
      .missedSym (missedSym)
   );

   // one accumulator per trellis state
   for (genvar s = 0; s < `NUM_STATES; s++) begin : genAcc
      metricAccumulator acc (
         .clk       (clk),
         .reset     (reset),
         .update    (update),
         .branchMet (bmBank[s]),
         .normVal   (normVal),
         .accMet    (accBank[s])
      );
   end

   maxMetricFinder finder (
      .clk      (clk),
      .reset    (reset),
      .update   (update),
      .accBank  (accBank),
      .result   (result),
      .maxValid (maxValid),
      .normVal  (normVal)
   );

endmodule

/* tb/tbTrellisMetric.sv */
`timescale 1ns/1ps
`include "trellis_config.svh"

module tbTrellisMetric;

   localparam int numStates    = `NUM_STATES;
   localparam int maxMetric    = (2 ** (`METRIC_WIDTH - 1)) - 1;
   localparam int minMetric    = -(2 ** (`METRIC_WIDTH - 1));
   localparam int latency      = 5;    // sampled symEn edge to maxValid
   localparam int totalSymbols = 35;   // accepted plus early strobes
   localparam int watchdogNs   = totalSymbols * 80 * 4 + 2000;

   logic                   clk;
   logic                   reset;
   logic                   bmEn;
   trellisPkg::metric_t    bmData;
   logic                   symEn;
   logic                   symAccept;   // set along with a symEn that should commit
   trellisPkg::maxResult_t result;
   logic                   maxValid;
   logic                   missedSym;

   // model state
   trellisPkg::metric_t    modelAcc [numStates];
   trellisPkg::metric_t    modelNorm;
   trellisPkg::maxResult_t expQ [$];
   int                     symEdgeQ [$];   // edge on which each accepted symEn was sampled

   int    cycleCount = 0;
   int    checkCount = 0;
   int    errorCount = 0;
   int    acceptCount = 0;
   int    validCount = 0;
   int    missCount = 0;
   int    earlyStrobes = 0;
   int    testStartErrors = 0;
   string testName = "";

   trellisMetricUnit uut (
      .clk       (clk),
      .reset     (reset),
      .bmEn      (bmEn),
      .bmData    (bmData),
      .symEn     (symEn),
      .result    (result),
      .maxValid  (maxValid),
      .missedSym (missedSym)
   );

   always #2 clk = ~clk;

   // add branch metric, remove last max, clamp, then pick the max
   // with ties going to the highest state index
   function automatic trellisPkg::maxResult_t modelSymbol(input trellisPkg::metricBank_t branch);
      trellisPkg::maxResult_t best;
      int sum;
      for (int i = 0; i < numStates; i++) begin
         sum = int'(modelAcc[i]) + int'(branch[i]) - int'(modelNorm);
         if (sum > maxMetric) begin
            sum = maxMetric;
         end else if (sum < minMetric) begin
            sum = minMetric;
         end
         modelAcc[i] = trellisPkg::metric_t'(sum);
      end
      best.index = '0;
      best.value = modelAcc[0];
      for (int i = 1; i < numStates; i++) begin
         if (modelAcc[i] >= best.value) begin
            best.value = modelAcc[i];
            best.index = trellisPkg::stateIndex_t'(i);
         end
      end
      modelNorm = best.value;   // normalization term of the next symbol
      return best;
   endfunction

   function automatic trellisPkg::metricBank_t randomBank();
      trellisPkg::metricBank_t bank;
      for (int i = 0; i < numStates; i++) begin
         bank[i] = trellisPkg::metric_t'(int'($urandom_range(0, 1023)) - 512);
      end
      return bank;
   endfunction

   task automatic compareResult(input string name, input trellisPkg::maxResult_t expected,
                                input trellisPkg::maxResult_t actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAILED %s: expected index %0d value %0d, actual index %0d value %0d",
                  name, expected.index, $signed(expected.value),
                  actual.index, $signed(actual.value));
      end
   endtask

   task automatic compareLatency(input string name, input int expected, input int actual);
      checkCount++;
      if (actual != expected) begin
         errorCount++;
         $display("%s: maxValid came %0d cycles after the accepted symEn instead of %0d",
                  name, actual, expected);
      end
   endtask

   task automatic expectLow(input string what, input logic value);
      checkCount++;
      if (value !== 1'b0) begin
         errorCount++;
         $display("%s: %s is not low after reset", testName, what);
      end
   endtask

   task automatic startTest(input string name);
      testName = name;
      testStartErrors = errorCount;
   endtask

   task automatic endTest();
      $display("%-14s %s, %0d errors", testName,
               (errorCount == testStartErrors) ? "ok" : "failed",
               errorCount - testStartErrors);
   endtask

   // serial load, one word per cycle, back to back
   task automatic loadWords(input trellisPkg::metricBank_t bank, input int first,
                            input int last);
      for (int i = first; i <= last; i++) begin
         @(posedge clk);
         bmEn   <= 1'b1;
         bmData <= bank[i];
      end
      @(posedge clk);
      bmEn <= 1'b0;
   endtask

   task automatic strobeSym(input logic accept);
      @(posedge clk);
      symEn     <= 1'b1;
      symAccept <= accept;
      @(posedge clk);
      symEn     <= 1'b0;
      symAccept <= 1'b0;
   endtask

   task automatic commitSymbol(input trellisPkg::metricBank_t bank);
      loadWords(bank, 0, numStates - 1);
      expQ.push_back(modelSymbol(bank));
      strobeSym(1'b1);
   endtask

   task automatic drainResults();
      while (expQ.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk);
   endtask

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
   end

   // outputs are read mid-cycle, away from the active edge
   always @(negedge clk) begin : checkOutputs
      trellisPkg::maxResult_t expected;
      int symEdge;
      if (!reset) begin
         if (symEn && symAccept) begin
            symEdgeQ.push_back(cycleCount + 1);   // DUT samples on the next edge
            acceptCount++;
         end
         if (missedSym) begin
            missCount++;
         end
         if (maxValid) begin
            validCount++;
            if (expQ.size() == 0 || symEdgeQ.size() == 0) begin
               errorCount++;
               $display("%s: maxValid pulsed with no accepted symbol waiting", testName);
            end else begin
               expected = expQ.pop_front();
               symEdge  = symEdgeQ.pop_front();
               compareResult(testName, expected, result);
               compareLatency(testName, latency, cycleCount - symEdge);
            end
         end
      end
   end

   initial begin : watchdog
      #(watchdogNs);
      $display("watchdog: run did not finish within %0d ns", watchdogNs);
      $display("TB FAILED");
      $finish;
   end

   initial begin : mainSequence
      trellisPkg::metricBank_t bank;
      int missBefore;
      int acceptBefore;
      int validBefore;
      clk       = 1'b0;
      reset     = 1'b1;
      bmEn      = 1'b0;
      bmData    = '0;
      symEn     = 1'b0;
      symAccept = 1'b0;
      modelNorm = '0;
      for (int i = 0; i < numStates; i++) begin
         modelAcc[i] = '0;
      end
      void'($urandom(32'he4));
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      startTest("resetState");
      repeat (4) begin
         @(negedge clk);
         compareResult(testName, '0, result);
         expectLow("maxValid", maxValid);
         expectLow("missedSym", missedSym);
      end
      endTest();

      startTest("randomSymbols");
      for (int s = 0; s < 20; s++) begin
         commitSymbol(randomBank());
      end
      drainResults();
      endTest();

      startTest("ties");
      for (int i = 0; i < numStates; i++) begin
         bank[i] = trellisPkg::metric_t'(minMetric);   // floors every state alike
      end
      commitSymbol(bank);
      for (int i = 0; i < numStates; i++) begin
         bank[i] = trellisPkg::metric_t'(100);
      end
      commitSymbol(bank);
      for (int i = 0; i < numStates; i++) begin
         bank[i] = '0;
      end
      bank[5]  = trellisPkg::metric_t'(50);
      bank[17] = trellisPkg::metric_t'(50);
      bank[42] = trellisPkg::metric_t'(50);
      commitSymbol(bank);
      for (int i = 0; i < numStates; i++) begin
         bank[i] = '0;
      end
      bank[7]  = trellisPkg::metric_t'(200);
      bank[33] = trellisPkg::metric_t'(200);
      bank[60] = trellisPkg::metric_t'(200);
      commitSymbol(bank);
      drainResults();
      endTest();

      startTest("saturation");
      for (int s = 0; s < 6; s++) begin
         for (int i = 0; i < numStates; i++) begin
            case (i % 4)
               0: bank[i] = trellisPkg::metric_t'(minMetric);
               1: bank[i] = trellisPkg::metric_t'(maxMetric);
               2: bank[i] = trellisPkg::metric_t'(int'($urandom_range(0, 4095)) - 2048);
               default: begin
                  bank[i] = trellisPkg::metric_t'((s % 2 == 0) ? maxMetric : minMetric);
               end
            endcase
         end
         commitSymbol(bank);
      end
      drainResults();
      endTest();

      startTest("latencyValid");
      acceptBefore = acceptCount;
      validBefore  = validCount;
      for (int s = 0; s < 3; s++) begin
         commitSymbol(randomBank());
      end
      drainResults();
      checkCount++;
      if ((validCount - validBefore) != (acceptCount - acceptBefore)) begin
         errorCount++;
         $display("%s: %0d maxValid pulses for %0d accepted symbols", testName,
                  validCount - validBefore, acceptCount - acceptBefore);
      end
      endTest();

      startTest("earlySymbol");
      missBefore = missCount;
      bank = randomBank();
      loadWords(bank, 0, 19);
      strobeSym(1'b0);   // bank only part loaded
      earlyStrobes++;
      repeat (8) @(posedge clk);
      checkCount++;
      if (missCount != missBefore + 1) begin
         errorCount++;
         $display("%s: missedSym did not pulse once for the early symEn", testName);
      end
      loadWords(bank, 20, numStates - 1);
      expQ.push_back(modelSymbol(bank));
      strobeSym(1'b1);
      drainResults();
      endTest();

      checkCount++;
      if (expQ.size() != 0 || symEdgeQ.size() != 0) begin
         errorCount++;
         $display("results still outstanding at the end of the run");
      end
      checkCount++;
      if (missCount != earlyStrobes) begin
         errorCount++;
         $display("missedSym pulsed %0d times for %0d early strobes", missCount, earlyStrobes);
      end
      $display("checks %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

/* trellisMetric.f */
+incdir+design
design/trellisPkg.sv
design/branchMetricLoader.sv
design/metricAccumulator.sv
design/comp4Max.sv
design/maxMetricFinder.sv
design/trellisMetricUnit.sv
tb/tbTrellisMetric.sv

/* run.sh */
#!/bin/bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
   --top-module tbTrellisMetric \
   -f trellisMetric.f \
   -o simTrellisMetric

./obj_dir/simTrellisMetric | tee sim.log

if grep -q "TB FAILED" sim.log; then
   echo "simulation reported failure"
   exit 1
fi

echo "simulation finished without failure"
exit 0
